// File: build.f
+incdir+.
riscv_isa_pkg.sv
r5p_alu.sv
r5p_decode.sv
r5p_writeback.sv
r5p_alu_cluster.sv
r5p_alu_cluster_tb.sv

// File: Makefile
# Verilator build and run of the ALU cluster testbench
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f build.f --top-module r5p_alu_cluster_tb -Mdir obj_dir
	./obj_dir/Vr5p_alu_cluster_tb > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	! grep -q "Checks failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// File: r5p_alu_cluster_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench of the ALU cluster, LFSR batches against a behavioral model,
// closing with a register file sweep over the debug port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "r5p_config.svh"

module r5p_alu_cluster_tb;

localparam int XLEN       = `R5P_XLEN;
localparam int LANES      = `R5P_LANES;
localparam int SHW        = $clog2(XLEN);              // shamt width
localparam int RST_CYCLES = 16;
localparam int N_CYCLES   = 400;                       // stimulus cycles
localparam int MAX_CYCLES = RST_CYCLES + N_CYCLES + 50;

// expected retire report of one batch
typedef struct packed {
  logic                                 rv;
  riscv_isa_pkg::lane_ret_t [LANES-1:0] lane;
} expect_t;

logic                                 clk;
logic                                 rst;
logic                                 in_valid;
logic [LANES-1:0]                     in_lane_en;
riscv_isa_pkg::instr_t [LANES-1:0]    in_instr;
logic [XLEN-1:0]                      in_pc;
riscv_isa_pkg::lane_ret_t [LANES-1:0] ret;
logic                                 ret_valid;
riscv_isa_pkg::reg_addr_t             dbg_addr;
riscv_isa_pkg::xlen_t                 dbg_data;

logic [31:0]     lfsr;
logic [XLEN-1:0] regs [`R5P_NREGS];  // model register file
expect_t         pend [$];           // reports in flight, two deep
int              n_checks;
int              n_errors;
int              cycles;

r5p_alu_cluster r5p_alu_cluster_i (
  .clk        (clk),
  .rst        (rst),
  .in_valid   (in_valid),
  .in_lane_en (in_lane_en),
  .in_instr   (in_instr),
  .in_pc      (in_pc),
  .ret        (ret),
  .ret_valid  (ret_valid),
  .dbg_addr   (dbg_addr),
  .dbg_data   (dbg_data)
);

initial begin
  clk = 1'b0;
  forever #5 clk = ~clk;  // 10 ns
end

////////////////////////////////////////////////////////////////////////////
// random source
////////////////////////////////////////////////////////////////////////////

// x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// n fresh bits, one step per bit
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int b = 0; b < n; b++) begin
    lfsr = lfsr_next(lfsr);
    v    = {v[30:0], lfsr[0]};
  end
  return v;
endfunction

// weighted opcode pick, about one junk opcode in 16
function automatic logic [31:0] make_instr();
  logic [3:0]  sel;
  logic [6:0]  opc;
  logic [6:0]  f7;
  logic [31:0] i;
  sel = 4'(rand_bits(4));
  if (sel < 6) opc = 7'b0110011;        // OP
  else if (sel < 12) opc = 7'b0010011;  // OP-IMM
  else if (sel == 12) opc = 7'b0110111; // LUI
  else if (sel == 13) opc = 7'b0010111; // AUIPC
  else if (sel == 14) opc = rand_bits(1) ? 7'b0111011 : 7'b0011011;  // word ops
  else opc = 7'(rand_bits(7));
  // funct7 mostly 0x00 / 0x20, now and then anything
  if (rand_bits(3) == 0) f7 = 7'(rand_bits(7));
  else f7 = {1'b0, 1'(rand_bits(1)), 5'b00000};
  i = {f7, 18'(rand_bits(18)), opc};
  // full immediates for non-shift OP-IMM and the U-types
  if ((opc == 7'b0010011 && i[13:12] != 2'b01) || opc == 7'b0110111 || opc == 7'b0010111)
    i[31:20] = 12'(rand_bits(12));
  return i;
endfunction

////////////////////////////////////////////////////////////////////////////
// reference model, RV32I/RV64I integer rules
////////////////////////////////////////////////////////////////////////////

function automatic void run_lane(input logic [31:0] i, input logic [XLEN-1:0] pc,
                                 output logic bad, output logic [XLEN-1:0] v);
  logic [2:0]      f3;
  logic [6:0]      f7;
  logic [11:0]     hi;     // immediate bits above shamt
  logic [XLEN-1:0] a;
  logic [XLEN-1:0] b;
  logic [XLEN-1:0] u;      // U-type immediate
  logic            sub;    // sub / sra
  logic            word;
  logic            f7_ok;
  int              sh;
  f3    = i[14:12];
  f7    = i[31:25];
  hi    = i[31:20] >> SHW;
  a     = regs[i[19:15]];
  b     = regs[i[24:20]];
  u     = XLEN'(signed'({i[31:12], 12'h000}));
  sub   = i[30];
  word  = (i[6:0] == 7'b0111011) || (i[6:0] == 7'b0011011);
  f7_ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
  bad   = 1'b0;
  v     = '0;
  case (i[6:0])
    7'b0110011: bad = !f7_ok;
    7'b0010011: begin
      b   = XLEN'(signed'(i[31:20]));
      sub = i[30] && f3 == 3'd5;  // srai only
      if (f3 == 3'd1 || f3 == 3'd5) bad = !(hi == 0 || (sub && hi == (12'h400 >> SHW)));
    end
    7'b0111011: bad = XLEN != 64 || !(f3 inside {3'd0, 3'd1, 3'd5}) || !f7_ok;
    7'b0011011: begin
      b   = XLEN'(signed'(i[31:20]));
      sub = i[30] && f3 == 3'd5;
      bad = XLEN != 64 || !(f3 inside {3'd0, 3'd1, 3'd5}) ||
            (f3 != 3'd0 && !(f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd5)));
    end
    7'b0110111: begin
      v = u;  // lui
      return;
    end
    7'b0010111: begin
      v = pc + u;  // auipc
      return;
    end
    default: begin
      bad = 1'b1;
      return;
    end
  endcase
  sh = word ? int'(b[4:0]) : int'(b[SHW-1:0]);
  case (f3)
    3'd0: v = sub ? a - b : a + b;
    3'd1: v = a << sh;
    3'd2: v = XLEN'($signed(a) < $signed(b));
    3'd3: v = XLEN'(a < b);
    3'd4: v = a ^ b;
    3'd5: begin
      if (sub) v = word ? XLEN'($signed(a[31:0]) >>> sh) : XLEN'($signed(a) >>> sh);
      else v = word ? XLEN'(a[31:0] >> sh) : a >> sh;
    end
    3'd6: v = a | b;
    default: v = a & b;
  endcase
  if (word) v = XLEN'(signed'(v[31:0]));  // word results sign extended
endfunction

task automatic compare(input string what, input int idx,
                       input logic [63:0] got, input logic [63:0] exp);
  n_checks++;
  if (got !== exp) begin
    n_errors++;
    $display("ERR %0t: %s[%0d] is %h, expected %h", $time, what, idx, got, exp);
  end
endtask

// retire report of the batch two cycles back
task automatic check_report(input expect_t e);
  compare("ret_valid", 0, 64'(ret_valid), 64'(e.rv));
  for (int k = 0; k < LANES; k++) begin
    compare("ret.valid", k, 64'(ret[k].valid), 64'(e.lane[k].valid));
    if (e.lane[k].valid) begin
      compare("ret.illegal", k, 64'(ret[k].illegal), 64'(e.lane[k].illegal));
      if (!e.lane[k].illegal) begin
        compare("ret.rd_addr", k, 64'(ret[k].rd_addr), 64'(e.lane[k].rd_addr));
        compare("ret.data", k, 64'(ret[k].data), 64'(e.lane[k].data));
      end
    end
  end
endtask

////////////////////////////////////////////////////////////////////////////
// stimulus and checking
////////////////////////////////////////////////////////////////////////////

initial begin
  logic [XLEN-1:0] vals [LANES];
  logic            bads [LANES];
  expect_t         e;
  rst        = 1'b1;
  in_valid   = 1'b0;
  in_lane_en = '0;
  in_instr   = '0;
  in_pc      = '0;
  dbg_addr   = '0;
  lfsr       = 32'd50;
  n_checks   = 0;
  n_errors   = 0;
  for (int r = 0; r < `R5P_NREGS; r++) regs[r] = '0;
  repeat (RST_CYCLES) @(posedge clk);
  #1 rst = 1'b0;
  pend.push_back('0);  // idle right after reset
  pend.push_back('0);
  for (int n = 0; n < N_CYCLES + 2; n++) begin
    @(posedge clk);
    #1;
    check_report(pend.pop_front());
    e = '0;
    if (n < N_CYCLES) begin
      in_valid   = (rand_bits(2) != 0);  // about 3 in 4
      in_lane_en = LANES'(rand_bits(LANES));
      in_pc      = '0;
      for (int b = 0; b < XLEN; b += 16) in_pc = (in_pc << 16) | XLEN'(rand_bits(16));
      in_pc[1:0] = 2'b00;
      for (int k = 0; k < LANES; k++) in_instr[k] = make_instr();
    end else begin
      in_valid = 1'b0;  // drain
    end
    // every lane reads the state before the batch
    for (int k = 0; k < LANES; k++) begin
      run_lane(in_instr[k], in_pc + XLEN'(4 * k), bads[k], vals[k]);
      e.lane[k].valid   = in_valid & in_lane_en[k];
      e.lane[k].illegal = bads[k] & e.lane[k].valid;
      e.lane[k].rd_addr = in_instr[k][11:7];
      e.lane[k].data    = vals[k];
    end
    e.rv = in_valid & (|in_lane_en);
    // ascending lane order, last lane on an equal rd wins
    for (int k = 0; k < LANES; k++) begin
      if (e.lane[k].valid && !bads[k] && e.lane[k].rd_addr != 0)
        regs[e.lane[k].rd_addr] = vals[k];
    end
    pend.push_back(e);
  end
  // final register file sweep
  for (int r = 0; r < `R5P_NREGS; r++) begin
    dbg_addr = riscv_isa_pkg::reg_addr_t'(r);
    #1;
    compare("dbg_data", r, 64'(dbg_data), 64'(regs[r]));
  end
  $display("%0d checks, %0d errors", n_checks, n_errors);
  if (n_errors == 0) begin
    $display("All checks passed");
  end else begin
    $display("Checks failed");
  end
  $finish;
end

// run limit in clock cycles
initial begin
  cycles = 0;
  while (cycles < MAX_CYCLES) begin
    @(posedge clk);
    cycles++;
  end
  $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
  $display("Checks failed");
  $finish;
end

endmodule: r5p_alu_cluster_tb

`default_nettype wire

// File: r5p_alu_cluster.sv
////////////////////////////////////////////////////////////////////////////
// four-lane integer execution cluster, decoder, per-lane ALUs and
// writeback; a batch retires two cycles after its strobe
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "r5p_config.svh"

module r5p_alu_cluster (
  input  logic                                       clk,
  input  logic                                       rst,
  // batch input
  input  logic                                       in_valid,
  input  logic [`R5P_LANES-1:0]                      in_lane_en,
  input  riscv_isa_pkg::instr_t [`R5P_LANES-1:0]     in_instr,
  input  logic [`R5P_XLEN-1:0]                       in_pc,
  // retire report
  output riscv_isa_pkg::lane_ret_t [`R5P_LANES-1:0]  ret,
  output logic                                       ret_valid,
  // register file debug read
  input  riscv_isa_pkg::reg_addr_t                   dbg_addr,
  output riscv_isa_pkg::xlen_t                       dbg_data
);

riscv_isa_pkg::lane_req_t [`R5P_LANES-1:0] req;       // decoded lanes
riscv_isa_pkg::xlen_t     [`R5P_LANES-1:0] res;       // ALU results
riscv_isa_pkg::reg_addr_t [`R5P_LANES-1:0] rs1_addr;
riscv_isa_pkg::reg_addr_t [`R5P_LANES-1:0] rs2_addr;
riscv_isa_pkg::xlen_t     [`R5P_LANES-1:0] rs1_data;
riscv_isa_pkg::xlen_t     [`R5P_LANES-1:0] rs2_data;

r5p_decode r5p_decode_i (
  .clk        (clk),
  .rst        (rst),
  .in_valid   (in_valid),
  .in_lane_en (in_lane_en),
  .in_instr   (in_instr),
  .in_pc      (in_pc),
  .req        (req)
);

// one ALU per lane
for (genvar k = 0; k < `R5P_LANES; k++) begin : g_lane
  assign rs1_addr[k] = req[k].rs1_addr;
  assign rs2_addr[k] = req[k].rs2_addr;

  r5p_alu r5p_alu_i (
    .ctl (req[k].ctl),
    .imm (req[k].imm),
    .pc  (req[k].pc),
    .rs1 (rs1_data[k]),
    .rs2 (rs2_data[k]),
    .rd  (res[k])
  );
end

r5p_writeback r5p_writeback_i (
  .clk       (clk),
  .rst       (rst),
  .req       (req),
  .res       (res),
  .rs1_addr  (rs1_addr),
  .rs2_addr  (rs2_addr),
  .rs1_data  (rs1_data),
  .rs2_data  (rs2_data),
  .dbg_addr  (dbg_addr),
  .dbg_data  (dbg_data),
  .ret       (ret),
  .ret_valid (ret_valid)
);

endmodule: r5p_alu_cluster

`default_nettype wire

// File: r5p_writeback.sv
////////////////////////////////////////////////////////////////////////////
// register file and retire stage, writes lane results in lane order and
// registers the per-lane retire report
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "r5p_config.svh"

module r5p_writeback (
  input  logic                                           clk,
  input  logic                                           rst,
  input  riscv_isa_pkg::lane_req_t  [`R5P_LANES-1:0]     req,
  input  riscv_isa_pkg::xlen_t      [`R5P_LANES-1:0]     res,       // ALU results
  input  riscv_isa_pkg::reg_addr_t  [`R5P_LANES-1:0]     rs1_addr,
  input  riscv_isa_pkg::reg_addr_t  [`R5P_LANES-1:0]     rs2_addr,
  output riscv_isa_pkg::xlen_t      [`R5P_LANES-1:0]     rs1_data,
  output riscv_isa_pkg::xlen_t      [`R5P_LANES-1:0]     rs2_data,
  input  riscv_isa_pkg::reg_addr_t                       dbg_addr,
  output riscv_isa_pkg::xlen_t                           dbg_data,
  output riscv_isa_pkg::lane_ret_t  [`R5P_LANES-1:0]     ret,
  output logic                                           ret_valid
);

localparam int unsigned LANES = `R5P_LANES;

riscv_isa_pkg::xlen_t [`R5P_NREGS-1:0] rf;  // rf[0] is never written
logic [LANES-1:0] we;                       // per-lane write enable
logic             any_valid;

always_comb begin
  for (int k = 0; k < LANES; k++) begin
    we[k] = req[k].valid & ~req[k].illegal & (req[k].rd_addr != '0);  // x0 dropped
  end
end

assign any_valid = lane_any(req);

// any lane valid in the batch
function automatic logic lane_any(input riscv_isa_pkg::lane_req_t [LANES-1:0] r);
  logic a;
  a = 1'b0;
  for (int k = 0; k < LANES; k++) a |= r[k].valid;
  return a;
endfunction

// any lane valid in a retire report
function automatic logic ret_any(input riscv_isa_pkg::lane_ret_t [LANES-1:0] r);
  logic a;
  a = 1'b0;
  for (int k = 0; k < LANES; k++) a |= r[k].valid;
  return a;
endfunction

////////////////////////////////////////////////////////////////////////////
// register file
////////////////////////////////////////////////////////////////////////////

// ascending order, so the last lane on an equal rd wins
always_ff @(posedge clk) begin
  if (rst) begin
    rf <= '0;
  end else begin
    for (int k = 0; k < LANES; k++) begin
      if (we[k]) rf[req[k].rd_addr] <= res[k];
    end
  end
end

// operand reads see the state before this batch
always_comb begin
  for (int k = 0; k < LANES; k++) begin
    rs1_data[k] = rf[rs1_addr[k]];
    rs2_data[k] = rf[rs2_addr[k]];
  end
end

assign dbg_data = rf[dbg_addr];

////////////////////////////////////////////////////////////////////////////
// retire report
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk) begin
  for (int k = 0; k < LANES; k++) begin
    ret[k].valid   <= req[k].valid;
    ret[k].illegal <= req[k].illegal;
    ret[k].rd_addr <= req[k].rd_addr;
    ret[k].data    <= res[k];
  end
  ret_valid <= any_valid;
  if (rst) begin
    for (int k = 0; k < LANES; k++) ret[k].valid <= 1'b0;
    ret_valid <= 1'b0;
  end
end

// report strobe only with a live lane in it
ret_has_lane: assert property (@(posedge clk) disable iff (rst)
  ret_valid |-> ret_any(ret));

endmodule: r5p_writeback

`default_nettype wire

// File: r5p_decode.sv
////////////////////////////////////////////////////////////////////////////
// batch decoder, turns up to R5P_LANES words into registered lane requests
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "r5p_config.svh"

module r5p_decode (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       in_valid,    // batch strobe
  input  logic [`R5P_LANES-1:0]                      in_lane_en,  // per-lane enable
  input  riscv_isa_pkg::instr_t [`R5P_LANES-1:0]     in_instr,
  input  logic [`R5P_XLEN-1:0]                       in_pc,       // pc of lane 0
  output riscv_isa_pkg::lane_req_t [`R5P_LANES-1:0]  req
);

localparam int unsigned XLEN  = `R5P_XLEN;
localparam int unsigned LANES = `R5P_LANES;
localparam int unsigned SHW   = $clog2(XLEN);  // shamt width of OP-IMM shifts

riscv_isa_pkg::lane_req_t [LANES-1:0] dec;  // decoded, before the register

// decode one word, valid is filled in by the caller
function automatic riscv_isa_pkg::lane_req_t decode(input logic [31:0]     i,
                                                    input logic [XLEN-1:0] pc);
  riscv_isa_pkg::lane_req_t r;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       r7_ok;   // funct7 of register ops
  logic       sh_ok;   // upper imm bits of OP-IMM shifts
  logic       shw_ok;  // same for OP-IMM-32
  logic       w3_ok;   // funct3 allowed in 32-bit ops
  logic       bad;
  f3     = i[14:12];
  f7     = i[31:25];
  r7_ok  = (f7 == 7'h00) || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
  sh_ok  = !i[31] && (i[29:20+SHW] == '0) && ((f3 == 3'd5) || !i[30]);
  shw_ok = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd5));
  w3_ok  = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd5);
  bad    = 1'b0;
  // defaults, register op with I-type immediate
  r          = '0;
  r.ctl.ai   = riscv_isa_pkg::AI_R1_R2;
  r.ctl.ao   = riscv_isa_pkg::AO_ADD;
  r.ctl.rt   = riscv_isa_pkg::R_SX;
  r.imm      = XLEN'(signed'(i[31:20]));
  r.pc       = pc;
  r.rs1_addr = i[19:15];
  r.rs2_addr = i[24:20];
  r.rd_addr  = i[11:7];
  case (i[6:0])
    riscv_isa_pkg::OP: begin
      r.ctl.ao = riscv_isa_pkg::ao_t'({i[30], f3});
      if (f3 == 3'd3) r.ctl.rt = riscv_isa_pkg::R_UX;  // sltu
      bad = !r7_ok;
    end
    riscv_isa_pkg::OP_IMM: begin
      r.ctl.ai = riscv_isa_pkg::AI_R1_IM;
      r.ctl.ao = riscv_isa_pkg::ao_t'({i[30] & (f3 == 3'd5), f3});  // srai only
      if (f3 == 3'd3) r.ctl.rt = riscv_isa_pkg::R_UX;  // sltiu
      bad = ((f3 == 3'd1) || (f3 == 3'd5)) && !sh_ok;
    end
    riscv_isa_pkg::OP_32: begin
      r.ctl.ao = riscv_isa_pkg::ao_t'({i[30], f3});
      r.ctl.rt = riscv_isa_pkg::R_SW;
      bad = (XLEN != 64) || !w3_ok || !r7_ok;
    end
    riscv_isa_pkg::OP_IMM_32: begin
      r.ctl.ai = riscv_isa_pkg::AI_R1_IM;
      r.ctl.ao = riscv_isa_pkg::ao_t'({i[30] & (f3 == 3'd5), f3});
      r.ctl.rt = riscv_isa_pkg::R_SW;
      bad = (XLEN != 64) || !w3_ok || ((f3 != 3'd0) && !shw_ok);
    end
    riscv_isa_pkg::LUI: begin
      r.ctl.ai   = riscv_isa_pkg::AI_R1_IM;
      r.imm      = XLEN'(signed'({i[31:12], 12'h000}));
      r.rs1_addr = '0;  // x0 + imm
    end
    riscv_isa_pkg::AUIPC: begin
      r.ctl.ai = riscv_isa_pkg::AI_PC_IM;
      r.imm    = XLEN'(signed'({i[31:12], 12'h000}));
    end
    default: bad = 1'b1;
  endcase
  // rejected word, harmless control and no destination
  if (bad) begin
    r.ctl.ao  = riscv_isa_pkg::AO_ADD;
    r.rd_addr = '0;
  end
  r.illegal = bad;
  return r;
endfunction

always_comb begin
  for (int k = 0; k < LANES; k++) begin
    dec[k]         = decode(in_instr[k], in_pc + XLEN'(4*k));
    dec[k].valid   = in_valid & in_lane_en[k];
    dec[k].illegal = dec[k].illegal & dec[k].valid;  // only reported for live lanes
  end
end

// request register, only valid bits are cleared
always_ff @(posedge clk) begin
  req <= dec;
  if (rst) begin
    for (int k = 0; k < LANES; k++) req[k].valid <= 1'b0;
  end
end

for (genvar k = 0; k < LANES; k++) begin : g_chk
  // a live rejected lane carries no register write
  illegal_no_write: assert property (@(posedge clk) disable iff (rst)
    (req[k].valid && req[k].illegal) |-> (req[k].rd_addr == '0));
end

endmodule: r5p_decode

`default_nettype wire

// File: r5p_alu.sv
////////////////////////////////////////////////////////////////////////////
// combinational integer ALU, one instance per cluster lane
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "r5p_config.svh"

module r5p_alu (
  input  riscv_isa_pkg::alu_t    ctl,  // control word
  input  logic [`R5P_XLEN-1:0]   imm,  // immediate
  input  logic [`R5P_XLEN-1:0]   pc,   // lane pc
  input  logic [`R5P_XLEN-1:0]   rs1,  // source register 1
  input  logic [`R5P_XLEN-1:0]   rs2,  // source register 2
  output logic [`R5P_XLEN-1:0]   rd    // result
);

localparam int unsigned XLEN = `R5P_XLEN;
localparam int unsigned SAW  = $clog2(XLEN);  // shift amount width

logic [XLEN-1:0]      in1;   // selected input 1
logic [XLEN-1:0]      in2;   // selected input 2
logic [XLEN:0]        op1;   // extended by one bit
logic [XLEN:0]        op2;
logic                 inv;   // subtract / compare
logic                 cmp;   // extension bit of the sum
logic [XLEN-1:0]      sum;
logic                 word;  // 32-bit op on RV64
logic [SAW-1:0]       sa;    // shift amount
logic [XLEN-1:0]      shr;   // logical right shift source
logic [XLEN-1:0]      val;   // result before word handling
riscv_isa_pkg::ao_f_t aof;

// one-bit extension by result type
function automatic logic [XLEN:0] ext(input logic [XLEN-1:0] v,
                                      input riscv_isa_pkg::rt_t rt);
  case (rt)
    riscv_isa_pkg::R_UX: ext = {1'b0, v};
    riscv_isa_pkg::R_SW: ext = (XLEN+1)'(signed'(v[31:0]));
    riscv_isa_pkg::R_UW: ext = (XLEN+1)'(v[31:0]);
    default:             ext = {v[XLEN-1], v};  // R_SX
  endcase
endfunction

// input multiplexer
always_comb begin
  case (ctl.ai)
    riscv_isa_pkg::AI_R1_IM: begin in1 = rs1; in2 = imm; end
    riscv_isa_pkg::AI_PC_IM: begin in1 = pc;  in2 = imm; end
    default:                 begin in1 = rs1; in2 = rs2; end
  endcase
end

assign aof  = ctl.ao;
assign word = (ctl.rt == riscv_isa_pkg::R_SW) || (ctl.rt == riscv_isa_pkg::R_UW);

////////////////////////////////////////////////////////////////////////////
// adder, shared by add/sub/slt/sltu
////////////////////////////////////////////////////////////////////////////

assign op1 = ext(in1, ctl.rt);
assign op2 = ext(in2, ctl.rt);

// sub and both compares take op1 - op2
assign inv = aof.f7_5 | (ctl.ao == riscv_isa_pkg::AO_SLT) | (ctl.ao == riscv_isa_pkg::AO_SLTU);

assign {cmp, sum} = op1 + (inv ? ~op2 : op2) + (XLEN+1)'(inv);  // cmp set when op1 < op2

////////////////////////////////////////////////////////////////////////////
// shifter and result select
////////////////////////////////////////////////////////////////////////////

assign sa  = word ? SAW'(in2[4:0]) : in2[SAW-1:0];  // word shifts use 5 bits
assign shr = word ? XLEN'(in1[31:0]) : in1;         // clear upper half for srlw

always_comb begin
  case (ctl.ao)
    riscv_isa_pkg::AO_ADD,
    riscv_isa_pkg::AO_SUB:  val = sum;
    riscv_isa_pkg::AO_SLT,
    riscv_isa_pkg::AO_SLTU: val = XLEN'(cmp);
    riscv_isa_pkg::AO_AND:  val = in1 & in2;
    riscv_isa_pkg::AO_OR:   val = in1 | in2;
    riscv_isa_pkg::AO_XOR:  val = in1 ^ in2;
    riscv_isa_pkg::AO_SRA:  val = XLEN'($signed(op1) >>> sa);  // op1 already sign extended
    riscv_isa_pkg::AO_SRL:  val = shr >> sa;
    riscv_isa_pkg::AO_SLL:  val = in1 << sa;
    default:                val = sum;
  endcase
end

// word results sign extended to XLEN
assign rd = word ? XLEN'(signed'(val[31:0])) : val;

// decoder only ever emits the three selections
always_comb begin
  ai_known: assert ($isunknown(ctl.ai) || ctl.ai inside {riscv_isa_pkg::AI_R1_R2,
                    riscv_isa_pkg::AI_R1_IM, riscv_isa_pkg::AI_PC_IM})
    else $error("ALU input select out of range: %0d", ctl.ai);
end

endmodule: r5p_alu

`default_nettype wire

// File: riscv_isa_pkg.sv
////////////////////////////////////////////////////////////////////////////
// RISC-V ISA encodings, ALU control word and per-lane request/retire
// records, referenced by scoped names from every cluster module
////////////////////////////////////////////////////////////////////////////

`default_nettype none

`include "r5p_config.svh"

package riscv_isa_pkg;

// basic data types
typedef logic [`R5P_XLEN-1:0]          xlen_t;      // register width
typedef logic [$clog2(`R5P_NREGS)-1:0] reg_addr_t;  // register index
typedef logic [32-1:0]                 instr_t;     // instruction word

// major opcodes handled by the cluster
typedef enum logic [6:0] {
  OP        = 7'b0110011,
  OP_IMM    = 7'b0010011,
  OP_32     = 7'b0111011,  // RV64 only
  OP_IMM_32 = 7'b0011011,  // RV64 only
  LUI       = 7'b0110111,
  AUIPC     = 7'b0010111
} opcode_t;

// ALU input selection
typedef enum logic [1:0] {
  AI_R1_R2 = 2'd0,  // rs1, rs2
  AI_R1_IM = 2'd1,  // rs1, immediate
  AI_PC_IM = 2'd2   // pc, immediate
} ai_t;

// result type, signedness and width
typedef enum logic [1:0] {
  R_SX = 2'd0,  //   signed XLEN
  R_UX = 2'd1,  // unsigned XLEN
  R_SW = 2'd2,  //   signed word
  R_UW = 2'd3   // unsigned word
} rt_t;

// field view of the ALU operation
typedef struct packed {
  logic       f7_5;  // funct7 bit 5
  logic [2:0] f3;    // funct3
} ao_f_t;

// ALU operation {funct7[5], funct3}
typedef enum logic [3:0] {
  AO_ADD  = 4'b0_000,
  AO_SUB  = 4'b1_000,
  AO_SLL  = 4'b0_001,
  AO_SLT  = 4'b0_010,
  AO_SLTU = 4'b0_011,
  AO_XOR  = 4'b0_100,
  AO_SRL  = 4'b0_101,
  AO_SRA  = 4'b1_101,
  AO_OR   = 4'b0_110,
  AO_AND  = 4'b0_111
} ao_t;

// ALU control word
typedef struct packed {
  ai_t ai;
  ao_t ao;
  rt_t rt;
} alu_t;

// one decoded lane, decoder to ALU and writeback
typedef struct packed {
  logic      valid;     // lane enabled in a valid batch
  logic      illegal;   // not decodable, no write
  alu_t      ctl;
  xlen_t     imm;
  xlen_t     pc;        // batch pc + 4*lane
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
} lane_req_t;

// one retired lane
typedef struct packed {
  logic      valid;
  logic      illegal;
  reg_addr_t rd_addr;
  xlen_t     data;      // ALU result
} lane_ret_t;

endpackage: riscv_isa_pkg

`default_nettype wire

// File: r5p_config.svh
////////////////////////////////////////////////////////////////////////////
// build-time sizes of the integer execution cluster
// included by the ISA package, the RTL and the testbench
////////////////////////////////////////////////////////////////////////////

`ifndef R5P_CONFIG_SVH
`define R5P_CONFIG_SVH

// data width, 32 or 64
`define R5P_XLEN 32

// parallel lanes per batch
`define R5P_LANES 4

// integer register count, x0 included
`define R5P_NREGS 32

`endif
